//--- hw/snake_defs.svh
`ifndef SNAKE_DEFS_SVH
`define SNAKE_DEFS_SVH

`default_nettype none

// grid and snake size
`define GRID_STEP   30
`define MAX_LEN     20
`define INIT_LEN    5
`define START_X     120
`define START_Y     -90

// crash bounds
`define WALL_X      375
`define WALL_Y_TOP  225
`define WALL_Y_BOT  -275
`define OBST_HALF   60     // centre block with open bounds

// food placement
`define FOOD_X_MOD  11
`define FOOD_Y_MOD  8
`define FOOD_X_MAX  360
`define FOOD_Y_TOP  220
`define FOOD_PARK   1000
`define RDM_MAX     1000

// tick multipliers per speed_ctrl value
`define SPEED_F0    8
`define SPEED_F1    6
`define SPEED_F2    4
`define SPEED_F3    3

`default_nettype wire

`endif

//--- hw/snake_pkg.sv
`include "snake_defs.svh"
`default_nettype none

package snake_pkg;

    typedef logic signed [11:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // index 0 is the head
    typedef point_t [`MAX_LEN-1:0] body_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } btn_t;

    typedef enum logic [2:0] {NONE, RIGHT, LEFT, UP, DOWN} heading_t;

    typedef enum logic [1:0] {IDLE, PLAY, OVER} game_state_t;

    typedef logic [4:0] len_t;

endpackage

`default_nettype wire

//--- hw/move_timer.sv
`timescale 1ns/1ps
`include "snake_defs.svh"
`default_nettype none

module move_timer #(
    parameter int TICK_BASE = 8333333
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       pause,
    input  logic [1:0] speed_ctrl,
    output logic       step
);

    logic [31:0] wait_cnt;
    logic [31:0] cnt;

    always_comb begin
        case (speed_ctrl)
            2'd0:    wait_cnt = 32'(TICK_BASE * `SPEED_F0);   // slowest
            2'd1:    wait_cnt = 32'(TICK_BASE * `SPEED_F1);
            2'd2:    wait_cnt = 32'(TICK_BASE * `SPEED_F2);
            default: wait_cnt = 32'(TICK_BASE * `SPEED_F3);
        endcase
    end

    // count 0..wait, then one step pulse
    always_ff @(posedge CLK) begin
        if (RESET || pause) begin
            cnt  <= '0;
            step <= 1'b0;
        end else if (cnt >= wait_cnt) begin  // >= so a speed drop ends the wait at once
            cnt  <= '0;
            step <= 1'b1;
        end else begin
            cnt  <= cnt + 32'd1;
            step <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/steer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module steer_fsm import snake_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  btn_t        btn,
    input  logic        crash,
    output game_state_t state,
    output heading_t    heading
);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= IDLE;
            heading <= NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (btn != '0) begin
                        state <= PLAY;
                    end
                end
                PLAY: begin
                    if (crash) begin
                        state <= OVER;
                    end
                    case (heading)
                        NONE: begin
                            // a first left would run into the body
                            if (btn.left || btn.right) begin
                                heading <= RIGHT;
                            end else if (btn.up) begin
                                heading <= UP;
                            end else if (btn.down) begin
                                heading <= DOWN;
                            end
                        end
                        RIGHT, LEFT: begin
                            if (btn.up) begin
                                heading <= UP;
                            end else if (btn.down) begin
                                heading <= DOWN;
                            end
                        end
                        default: begin   // UP or DOWN
                            if (btn.left) begin
                                heading <= LEFT;
                            end else if (btn.right) begin
                                heading <= RIGHT;
                            end
                        end
                    endcase
                end
                default: state <= OVER;  // held until reset
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/snake_body.sv
`timescale 1ns/1ps
`include "snake_defs.svh"
`default_nettype none

module snake_body import snake_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        step,
    input  game_state_t state,
    input  heading_t    heading,
    input  logic        eaten,
    output body_t       body,
    output len_t        length,
    output logic        crash
);

    localparam coord_t STEP = coord_t'(`GRID_STEP);

    logic   move_en;
    point_t next_head;
    logic   wall_hit;
    logic   obst_hit;
    logic   self_hit;

    assign move_en = step && (state == PLAY) && (heading != NONE);

    always_comb begin
        next_head = body[0];
        case (heading)
            RIGHT:   next_head.x = body[0].x + STEP;
            LEFT:    next_head.x = body[0].x - STEP;
            UP:      next_head.y = body[0].y + STEP;
            DOWN:    next_head.y = body[0].y - STEP;
            default: next_head = body[0];
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            // unused tail slots sit on segment 3
            for (int i = 0; i < `MAX_LEN; i++) begin
                body[i].x <= coord_t'(`START_X - `GRID_STEP * ((i < `INIT_LEN) ? i : 3));
                body[i].y <= coord_t'(`START_Y);
            end
        end else if (move_en) begin
            body[0] <= next_head;
            for (int i = 1; i < `MAX_LEN; i++) begin
                body[i] <= (i < length) ? body[i-1] : body[3];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            length <= len_t'(`INIT_LEN);
        end else if (eaten && (length < len_t'(`MAX_LEN))) begin
            length <= length + 1'b1;
        end
    end

    assign wall_hit = (body[0].x >= `WALL_X) || (body[0].x <= -`WALL_X)
                   || (body[0].y >= `WALL_Y_TOP) || (body[0].y <= `WALL_Y_BOT);

    assign obst_hit = (body[0].x > -`OBST_HALF) && (body[0].x < `OBST_HALF)
                   && (body[0].y > -`OBST_HALF) && (body[0].y < `OBST_HALF);

    always_comb begin
        self_hit = 1'b0;
        for (int i = 1; i < `MAX_LEN; i++) begin
            if (body[i] == body[0]) begin
                self_hit = 1'b1;
            end
        end
    end

    // seen one cycle after the head moves
    always_ff @(posedge CLK) begin
        if (RESET) begin
            crash <= 1'b0;
        end else begin
            crash <= wall_hit || obst_hit || self_hit;
        end
    end

endmodule

`default_nettype wire

//--- hw/food_placer.sv
`timescale 1ns/1ps
`include "snake_defs.svh"
`default_nettype none

module food_placer import snake_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  game_state_t state,
    input  body_t       body,
    output point_t      food,
    output logic        eaten
);

    logic [9:0] rdm;
    point_t     cand;
    logic       food_new;   // food moved on the last edge
    logic       head_hit;
    logic       out_bounds;
    logic       in_obst;
    logic       on_body;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            rdm <= '0;
        end else begin
            rdm <= (rdm == 10'(`RDM_MAX)) ? '0 : rdm + 10'd1;
        end
    end

    always_comb begin
        cand.x = coord_t'((rdm % `FOOD_X_MOD) * `GRID_STEP);
        cand.y = -coord_t'((rdm % `FOOD_Y_MOD) * `GRID_STEP);  // lower half only
    end

    assign head_hit = (body[0] == food);

    assign out_bounds = (food.x < 0) || (food.x > `FOOD_X_MAX)
                     || (food.y < `WALL_Y_BOT) || (food.y > `FOOD_Y_TOP);

    assign in_obst = (food.x > -`OBST_HALF) && (food.x < `OBST_HALF)
                  && (food.y > -`OBST_HALF) && (food.y < `OBST_HALF);

    always_comb begin
        on_body = 1'b0;
        for (int i = 0; i < `MAX_LEN; i++) begin
            if (body[i] == food) begin
                on_body = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            food.x   <= coord_t'(`FOOD_PARK);
            food.y   <= coord_t'(`FOOD_PARK);
            eaten    <= 1'b0;
            food_new <= 1'b0;
        end else if (state == IDLE) begin
            eaten    <= 1'b0;
            food_new <= 1'b0;
        end else if (head_hit && !food_new) begin
            food     <= cand;
            eaten    <= 1'b1;
            food_new <= 1'b1;
        end else if (out_bounds || in_obst || on_body) begin
            // dropped onto the head counts as a bad cell, not a meal
            food     <= cand;
            eaten    <= 1'b0;
            food_new <= 1'b1;
        end else begin
            eaten    <= 1'b0;
            food_new <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/snake_game.sv
`timescale 1ns/1ps
`default_nettype none

module snake_game import snake_pkg::*; #(
    parameter int TICK_BASE = 8333333
) (
    input  logic        CLK,
    input  logic        RESET,
    input  btn_t        btn,
    input  logic        pause,
    input  logic [1:0]  speed_ctrl,
    output logic        step,
    output point_t      head,
    output point_t      food,
    output len_t        length,
    output game_state_t state
);

    heading_t heading;
    body_t    body;
    logic     crash;
    logic     eaten;

    move_timer #(
        .TICK_BASE (TICK_BASE)
    ) move_timer_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .pause      (pause),
        .speed_ctrl (speed_ctrl),
        .step       (step)
    );

    steer_fsm steer_fsm_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .btn     (btn),
        .crash   (crash),
        .state   (state),
        .heading (heading)
    );

    snake_body snake_body_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .step    (step),
        .state   (state),
        .heading (heading),
        .eaten   (eaten),
        .body    (body),
        .length  (length),
        .crash   (crash)
    );

    food_placer food_placer_i (
        .CLK   (CLK),
        .RESET (RESET),
        .state (state),
        .body  (body),
        .food  (food),
        .eaten (eaten)
    );

    assign head = body[0];  // segment 0 register

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    input  logic reset_req,
    output logic CLK,
    output logic RESET
);

    logic por;

    initial begin
        CLK = 1'b0;
        por = 1'b1;
        repeat (5) @(posedge CLK);
        por <= 1'b0;
    end

    always #2 CLK = ~CLK;  // 4 ns period

    assign RESET = por | reset_req;

endmodule

`default_nettype wire

//--- tests/snake_game_chk.sv
`timescale 1ns/1ps
`include "snake_defs.svh"
`default_nettype none

module snake_game_chk import snake_pkg::*; (
    input logic        CLK,
    input logic        RESET,
    input logic        step,
    input point_t      head,
    input point_t      food,
    input len_t        length,
    input game_state_t state
);

    logic food_in_obst;

    assign food_in_obst = (food.x > -`OBST_HALF) && (food.x < `OBST_HALF)
                       && (food.y > -`OBST_HALF) && (food.y < `OBST_HALF);

    step_one_cycle: assert property (@(posedge CLK) disable iff (RESET) step |=> !step)
        else $error("step high two cycles in a row");

    length_range: assert property (@(posedge CLK) disable iff (RESET)
        ($past(length) <= length) && (length <= len_t'(`MAX_LEN)))
        else $error("length dropped or exceeded the maximum");

    head_frozen: assert property (@(posedge CLK) disable iff (RESET)
        (state == OVER) |=> $stable(head))
        else $error("head moved after game over");

    food_leaves_obst: assert property (@(posedge CLK) disable iff (RESET)
        (state != IDLE && food_in_obst) |=> !food_in_obst)
        else $error("food stayed inside the obstacle");

endmodule

bind snake_game snake_game_chk snake_game_chk_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .step   (step),
    .head   (head),
    .food   (food),
    .length (length),
    .state  (state)
);

`default_nettype wire

//--- tests/snake_game_tb.sv
`timescale 1ns/1ps
`include "snake_defs.svh"
`default_nettype none

module snake_game_tb import snake_pkg::*; ();

    localparam int TICK = 4;
    localparam int WATCHDOG_CYCLES = 60 * (TICK * `SPEED_F0 + 1) + 2000;

    logic        CLK;
    logic        RESET;
    logic        reset_req;
    btn_t        btn;
    logic        pause;
    logic [1:0]  speed_ctrl;
    logic        step;
    point_t      head;
    point_t      food;
    len_t        length;
    game_state_t state;

    int       errors;
    int       exp_len;      // model of the length
    point_t   exp_head;     // model of the head
    heading_t cmd_heading;  // heading the tb has commanded
    logic     running;      // game in play per the model

    clk_gen clk_gen_i (.reset_req(reset_req), .CLK(CLK), .RESET(RESET));

    snake_game #(.TICK_BASE(TICK)) snake_game_i (
        .CLK(CLK), .RESET(RESET), .btn(btn), .pause(pause), .speed_ctrl(speed_ctrl),
        .step(step), .head(head), .food(food), .length(length), .state(state)
    );

    function automatic point_t predict_head(point_t p, heading_t h, logic run);
        point_t n;
        n = p;
        if (run) begin
            case (h)
                RIGHT:   n.x = p.x + coord_t'(`GRID_STEP);
                LEFT:    n.x = p.x - coord_t'(`GRID_STEP);
                UP:      n.y = p.y + coord_t'(`GRID_STEP);
                DOWN:    n.y = p.y - coord_t'(`GRID_STEP);
                default: n = p;
            endcase
        end
        return n;
    endfunction

    function automatic logic in_obstacle(point_t p);
        return (p.x > -`OBST_HALF) && (p.x < `OBST_HALF)
            && (p.y > -`OBST_HALF) && (p.y < `OBST_HALF);
    endfunction

    function automatic logic is_fatal(point_t p);
        return (p.x >= `WALL_X) || (p.x <= -`WALL_X) || (p.y >= `WALL_Y_TOP)
            || (p.y <= `WALL_Y_BOT) || in_obstacle(p);
    endfunction

    function automatic logic food_allowed(point_t p);
        return (p.x >= 0) && (p.x <= 360) && (p.y >= -275) && (p.y <= 220)
            && !in_obstacle(p);
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // returns at the negedge where step is high
    task automatic wait_step(output int cycles);
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!step);
    endtask

    task automatic press(input btn_t b, input heading_t h);
        @(posedge CLK);
        btn <= b;
        @(posedge CLK);
        btn <= '0;
        cmd_heading = h;  // registered by the DUT on this edge
        running = 1'b1;
    endtask

    // one step, then the eat check if the head lands on the food
    task automatic advance(output logic ate);
        int     n;
        point_t f0;
        wait_step(n);
        f0 = food;
        @(posedge CLK);
        ate = (exp_head == f0);
        if (ate) begin
            if (exp_len < `MAX_LEN) begin
                exp_len++;
            end
            repeat (4) @(negedge CLK);
            expect_equal("length", 32'(length), 32'(exp_len));
            if (food == f0 || !food_allowed(food)) begin
                errors++;
                $display("food was not moved to a new allowed cell after eating");
            end
        end
    endtask

    task automatic speed_and_pause();
        int   n;
        int   plen;
        int   first_sp;
        int   factor [4];
        logic [1:0] sp;
        factor = '{`SPEED_F0, `SPEED_F1, `SPEED_F2, `SPEED_F3};
        first_sp = int'($urandom % 4);
        for (int t = 0; t < 6; t++) begin
            sp = 2'(t + first_sp);  // rotates through all four speeds
            plen = 40 + int'($urandom % 40);
            @(posedge CLK);
            speed_ctrl <= sp;
            wait_step(n);
            wait_step(n);  // resync to the new speed
            wait_step(n);
            expect_equal("step period", 32'(n), 32'(TICK * factor[sp] + 1));
            @(posedge CLK);
            pause <= 1'b1;
            @(posedge CLK);
            repeat (plen) begin
                @(negedge CLK);
                if (step) begin
                    errors++;
                    $display("step pulse seen while pause was high");
                end
            end
            @(posedge CLK);
            pause <= 1'b0;
        end
    endtask

    // compare process
    always begin
        @(negedge CLK);
        if (!RESET && step) begin
            exp_head = predict_head(exp_head, cmd_heading, running);
            if (running && is_fatal(exp_head)) begin
                running = 1'b0;
            end
            @(negedge CLK);
            expect_equal("head", 32'(head), 32'(exp_head));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("timeout: the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        point_t target;
        logic   ate;
        int     n;
        btn = '0;
        pause = 1'b0;
        speed_ctrl = 2'd0;
        reset_req = 1'b0;
        errors = 0;
        exp_len = `INIT_LEN;
        cmd_heading = NONE;
        running = 1'b0;
        exp_head.x = coord_t'(`START_X);
        exp_head.y = coord_t'(`START_Y);
        void'($urandom(32'hb429f5ce));

        @(negedge CLK);
        while (RESET) @(negedge CLK);
        expect_equal("state", 32'(state), 32'(IDLE));
        expect_equal("length", 32'(length), 32'(exp_len));
        expect_equal("head", 32'(head), 32'(exp_head));
        expect_equal("food.x", 32'(food.x), 32'(`FOOD_PARK));
        expect_equal("food.y", 32'(food.y), 32'(`FOOD_PARK));

        speed_and_pause();

        // game 1 where a first left goes right and then on into the right wall
        @(posedge CLK);
        speed_ctrl <= 2'd3;
        press('{left: 1'b0, right: 1'b1, up: 1'b0, down: 1'b0}, NONE);
        @(negedge CLK);
        expect_equal("state", 32'(state), 32'(PLAY));
        press('{left: 1'b1, right: 1'b0, up: 1'b0, down: 1'b0}, RIGHT);
        for (int k = 1; k <= 9; k++) begin
            advance(ate);
            if (k == 2) begin
                press('{left: 1'b1, right: 1'b0, up: 1'b0, down: 1'b0}, RIGHT);
            end
        end
        @(negedge CLK);
        expect_equal("head.x", 32'(head.x), 32'd390);
        wait_step(n);
        expect_equal("state", 32'(state), 32'(OVER));
        repeat (3) wait_step(n);

        // new game for eating
        @(posedge CLK);
        reset_req <= 1'b1;
        repeat (5) @(posedge CLK);
        reset_req <= 1'b0;
        exp_head.x = coord_t'(`START_X);
        exp_head.y = coord_t'(`START_Y);
        exp_len = `INIT_LEN;
        cmd_heading = NONE;
        running = 1'b0;
        @(negedge CLK);
        expect_equal("length", 32'(length), 32'(exp_len));

        // route goes down below the food rows, right past them, up, then left onto the food
        press('{left: 1'b0, right: 1'b0, up: 1'b0, down: 1'b1}, NONE);
        press('{left: 1'b0, right: 1'b0, up: 1'b0, down: 1'b1}, DOWN);
        ate = 1'b0;
        while (!ate && exp_head.y > -240) advance(ate);
        if (!ate) begin
            press('{left: 1'b0, right: 1'b1, up: 1'b0, down: 1'b0}, RIGHT);
            while (!ate && exp_head.x < 360) advance(ate);
        end
        if (!ate) begin
            press('{left: 1'b0, right: 1'b0, up: 1'b1, down: 1'b0}, UP);
            target = food;
            while (!ate && exp_head.y < target.y) advance(ate);
        end
        if (!ate) begin
            press('{left: 1'b1, right: 1'b0, up: 1'b0, down: 1'b0}, LEFT);
            while (!ate && exp_head.x > target.x) advance(ate);
        end
        if (!ate) begin
            errors++;
            $display("the snake finished its route without reaching the food");
        end
        wait_step(n);

        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- snake_game.f
+incdir+hw
hw/snake_pkg.sv
hw/move_timer.sv
hw/steer_fsm.sv
hw/snake_body.sv
hw/food_placer.sv
hw/snake_game.sv
tests/clk_gen.sv
tests/snake_game_chk.sv
tests/snake_game_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module snake_game_tb -f snake_game.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
